/* Bender.yml */
package:
  name: levinson_durbin

sources:
  - src/lpc_pkg.sv
  - src/alpha_norm.sv
  - src/coef_store.sv
  - src/div_32_unit.sv
  - src/lev_ctrl.sv
  - src/lev_durbin_top.sv
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/tb_lev_durbin.sv

/* levinson_durbin.f */
+incdir+tb
src/lpc_pkg.sv
src/alpha_norm.sv
src/coef_store.sv
src/div_32_unit.sv
src/lev_ctrl.sv
src/lev_durbin_top.sv
tb/tb_lev_durbin.sv

/* src/alpha_norm.sv */
`default_nettype none

module alpha_norm (
	input wire logic clock,
	input wire logic reset,
	input wire logic norm_start,
	input wire logic [31:0] norm_in,
	output logic norm_done,
	output lpc_pkg::dpf_t norm_mant,
	output logic [4:0] norm_exp
);

	logic busy;
	logic [31:0] val;
	logic [4:0] cnt;

	logic [31:0] cur;
	logic [4:0] cur_cnt;
	logic is_norm;

	// First check happens on the start cycle itself
	assign cur = busy ? val : norm_in;
	assign cur_cnt = busy ? cnt : 5'd0;
	assign is_norm = (cur == 32'd0) || (cur[30] != cur[31]);

	always_ff @(posedge clock) begin
		norm_done <= 1'b0;
		if (reset) begin
			busy <= 1'b0;
		end else if (busy || norm_start) begin
			if (is_norm) begin
				busy <= 1'b0;
				norm_done <= 1'b1;
				norm_mant <= lpc_pkg::l_extract(cur);
				norm_exp <= cur_cnt;
			end else begin
				busy <= 1'b1;
				val <= {cur[30:0], 1'b0};
				cnt <= cur_cnt + 5'd1;
			end
		end
	end

endmodule

`default_nettype wire

/* src/coef_store.sv */
`default_nettype none

module coef_store (
	input wire logic clock,
	input wire logic reset,
	input wire logic cs_we,
	input wire logic cs_bank,
	input wire logic [3:0] cs_idx,
	input wire lpc_pkg::dpf_t cs_wdata,
	input wire logic cs_swap,
	input wire logic [3:0] cs_idx_a,
	input wire logic [3:0] cs_idx_b,
	output lpc_pkg::dpf_t cs_rdata_a,
	output lpc_pkg::dpf_t cs_rdata_b
);

	lpc_pkg::dpf_t bank [0:1][1:lpc_pkg::ORDER];
	logic sel;
	logic wsel;

	// cs_bank high targets the next-order bank
	assign wsel = sel ^ cs_bank;

	// Both reads come from the current-order bank
	assign cs_rdata_a = bank[sel][cs_idx_a];
	assign cs_rdata_b = bank[sel][cs_idx_b];

	always_ff @(posedge clock) begin
		if (reset) begin
			sel <= 1'b0;
			for (int b = 0; b < 2; b++) begin
				for (int n = 1; n <= lpc_pkg::ORDER; n++) begin
					bank[b][n] <= '0;
				end
			end
		end else begin
			if (cs_swap) begin
				sel <= ~sel;
			end
			if (cs_we) begin
				bank[wsel][cs_idx] <= cs_wdata;
			end
		end
	end

endmodule

`default_nettype wire

/* src/div_32_unit.sv */
`default_nettype none

module div_32_unit (
	input wire logic clock,
	input wire logic reset,
	input wire logic div_start,
	input wire lpc_pkg::dpf_t div_num,
	input wire lpc_pkg::dpf_t div_den,
	output logic div_done,
	output lpc_pkg::dpf_t div_quot
);

	logic [1:0] phase;
	logic [3:0] cnt;
	logic [15:0] rem;
	logic [15:0] approx;
	lpc_pkg::dpf_t num;
	lpc_pkg::dpf_t den;
	lpc_pkg::dpf_t inv;

	logic [16:0] rem_sh;
	logic [16:0] rem_sub;
	logic take;
	logic signed [31:0] err;

	// One restoring step of 0x3fff / den_hi
	assign rem_sh = {rem, 1'b0};
	assign rem_sub = rem_sh - {1'b0, den.hl.hi};
	assign take = (rem_sh >= {1'b0, den.hl.hi});

	// Newton correction 1 - den * approx, in Q30
	assign err = lpc_pkg::l_sub(lpc_pkg::MAX_32, lpc_pkg::mpy_32_16(den, approx));

	always_ff @(posedge clock) begin
		div_done <= 1'b0;
		if (reset) begin
			phase <= lpc_pkg::D_IDLE;
		end else begin
			case (phase)
				lpc_pkg::D_IDLE: begin
					if (div_start) begin
						num <= div_num;
						den <= div_den;
						rem <= 16'h3fff;
						approx <= 16'd0;
						cnt <= 4'd0;
						phase <= lpc_pkg::D_STEP;
					end
				end
				lpc_pkg::D_STEP: begin
					cnt <= cnt + 4'd1;
					rem <= take ? rem_sub[15:0] : rem_sh[15:0];
					approx <= {approx[14:0], take};
					if (cnt == lpc_pkg::DIV_STEPS - 1) begin
						phase <= lpc_pkg::D_INV;
					end
				end
				lpc_pkg::D_INV: begin
					inv <= lpc_pkg::l_extract(lpc_pkg::mpy_32_16(lpc_pkg::l_extract(err), approx));
					phase <= lpc_pkg::D_MUL;
				end
				default: begin
					// Q29 product back to Q31
					div_quot.w <= lpc_pkg::l_shl(lpc_pkg::mpy_32(lpc_pkg::l_extract(num.w), inv), 9'd2);
					div_done <= 1'b1;
					phase <= lpc_pkg::D_IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* src/lev_ctrl.sv */
`default_nettype none

module lev_ctrl (
	input wire logic clock,
	input wire logic reset,
	input wire logic start,
	output logic done,
	output logic unstable,
	output logic [lpc_pkg::ADDR_W-1:0] mem_raddr,
	input wire logic [31:0] mem_rdata,
	output logic [lpc_pkg::ADDR_W-1:0] mem_waddr,
	output logic [31:0] mem_wdata,
	output logic mem_we,
	output logic div_start,
	output lpc_pkg::dpf_t div_num,
	output lpc_pkg::dpf_t div_den,
	input wire logic div_done,
	input wire lpc_pkg::dpf_t div_quot,
	output logic norm_start,
	output logic [31:0] norm_in,
	input wire logic norm_done,
	input wire lpc_pkg::dpf_t norm_mant,
	input wire logic [4:0] norm_exp,
	output logic cs_we,
	output logic cs_bank,
	output logic [3:0] cs_idx,
	output lpc_pkg::dpf_t cs_wdata,
	output logic cs_swap,
	output logic [3:0] cs_idx_a,
	output logic [3:0] cs_idx_b,
	input wire lpc_pkg::dpf_t cs_rdata_a,
	input wire lpc_pkg::dpf_t cs_rdata_b
);

	logic [lpc_pkg::STATE_W-1:0] state;
	lpc_pkg::dpf_t r [0:lpc_pkg::ORDER];
	lpc_pkg::dpf_t alp;
	lpc_pkg::dpf_t k;
	logic [8:0] alp_exp;
	logic signed [31:0] acc;
	logic pos;
	logic [3:0] i;
	logic [3:0] j;

	logic signed [31:0] t_sum;
	logic signed [31:0] t_quot;
	logic signed [31:0] t_k;
	logic signed [31:0] one_m_k2;
	logic signed [15:0] a_rnd;
	logic k_bad;

	// (sum << 4) + r[i], its sign decides the negation of the quotient
	assign t_sum = lpc_pkg::l_add(lpc_pkg::l_shl(acc, 9'd4), lpc_pkg::l_comp(r[i]));
	assign t_quot = pos ? lpc_pkg::l_negate(div_quot.w) : div_quot.w;
	assign t_k = lpc_pkg::l_shl(t_quot, alp_exp);
	assign one_m_k2 = lpc_pkg::l_sub(lpc_pkg::MAX_32, lpc_pkg::l_abs(lpc_pkg::mpy_32(k, k)));
	assign a_rnd = lpc_pkg::round_q12(cs_rdata_a);
	assign k_bad = (i != 4'd1) && (k.hl.hi > lpc_pkg::RC_LIMIT || k.hl.hi < -lpc_pkg::RC_LIMIT);

	assign div_start = (state == lpc_pkg::S_SUM) && (j == i);
	assign div_num.w = lpc_pkg::l_abs(t_sum);
	assign div_den = alp;

	assign norm_start = (state == lpc_pkg::S_ALP);
	assign norm_in = lpc_pkg::mpy_32(alp, lpc_pkg::l_extract(one_m_k2));

	////////////////////////////////////////
	// Coefficient store access
	// a[j] on port a, a[i-j] on port b

	assign cs_idx_a = j;
	assign cs_idx_b = i - j;
	assign cs_idx = j;
	assign cs_we = (state == lpc_pkg::S_UPD);
	// Order 1 writes a[1] straight into the current bank
	assign cs_bank = (i != 4'd1);
	assign cs_swap = (state == lpc_pkg::S_ALP) && (i != 4'd1);
	assign cs_wdata = (j == i) ?
		lpc_pkg::l_extract(lpc_pkg::l_shr(lpc_pkg::l_comp(k), 5'd4)) :
		lpc_pkg::l_extract(lpc_pkg::l_add(lpc_pkg::mpy_32(k, cs_rdata_b),
			lpc_pkg::l_comp(cs_rdata_a)));

	assign mem_raddr = {lpc_pkg::R_BASE[lpc_pkg::ADDR_W-1:4], j};

	always_comb begin
		mem_we = 1'b0;
		mem_waddr = {lpc_pkg::RC_BASE[lpc_pkg::ADDR_W-1:4], i - 4'd1};
		mem_wdata = {{16{k.hl.hi[15]}}, k.hl.hi};
		if (state == lpc_pkg::S_RC) begin
			mem_we = 1'b1;
		end else if (state == lpc_pkg::S_OUT) begin
			mem_we = 1'b1;
			mem_waddr = {lpc_pkg::A_BASE[lpc_pkg::ADDR_W-1:4], j};
			mem_wdata = (j == 4'd0) ? lpc_pkg::ONE_Q12 : {{16{a_rnd[15]}}, a_rnd};
		end
	end

	////////////////////////////////////////
	// Sequencer

	always_ff @(posedge clock) begin
		done <= 1'b0;
		unstable <= 1'b0;
		if (reset) begin
			state <= lpc_pkg::S_IDLE;
		end else begin
			case (state)
				lpc_pkg::S_IDLE: begin
					if (start) begin
						j <= 4'd0;
						state <= lpc_pkg::S_LOAD;
					end
				end
				lpc_pkg::S_LOAD: begin
					// Data trails the address by one cycle
					j <= j + 4'd1;
					if (j != 4'd0) begin
						r[j - 4'd1] <= mem_rdata;
					end
					if (j == lpc_pkg::ORDER + 1) begin
						alp <= r[0];
						alp_exp <= 9'd0;
						acc <= 32'sd0;
						i <= 4'd1;
						j <= 4'd1;
						state <= lpc_pkg::S_SUM;
					end
				end
				lpc_pkg::S_SUM: begin
					if (j == i) begin
						pos <= (t_sum > 0);
						state <= lpc_pkg::S_DIV;
					end else begin
						acc <= lpc_pkg::l_add(acc, lpc_pkg::mpy_32(r[j], cs_rdata_b));
						j <= j + 4'd1;
					end
				end
				lpc_pkg::S_DIV: begin
					if (div_done) begin
						k <= lpc_pkg::l_extract(t_k);
						state <= lpc_pkg::S_RC;
					end
				end
				lpc_pkg::S_RC: begin
					if (k_bad) begin
						done <= 1'b1;
						unstable <= 1'b1;
						state <= lpc_pkg::S_IDLE;
					end else begin
						j <= 4'd1;
						state <= lpc_pkg::S_UPD;
					end
				end
				lpc_pkg::S_UPD: begin
					if (j == i) begin
						state <= lpc_pkg::S_ALP;
					end else begin
						j <= j + 4'd1;
					end
				end
				lpc_pkg::S_ALP: begin
					state <= lpc_pkg::S_NORM;
				end
				lpc_pkg::S_NORM: begin
					if (norm_done) begin
						alp <= norm_mant;
						alp_exp <= alp_exp + norm_exp;
						if (i == lpc_pkg::ORDER) begin
							j <= 4'd0;
							state <= lpc_pkg::S_OUT;
						end else begin
							i <= i + 4'd1;
							j <= 4'd1;
							acc <= 32'sd0;
							state <= lpc_pkg::S_SUM;
						end
					end
				end
				lpc_pkg::S_OUT: begin
					if (j == lpc_pkg::ORDER) begin
						done <= 1'b1;
						state <= lpc_pkg::S_IDLE;
					end else begin
						j <= j + 4'd1;
					end
				end
				default: begin
					state <= lpc_pkg::S_IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* src/lev_durbin_top.sv */
`default_nettype none

module lev_durbin_top (
	input wire logic clock,
	input wire logic reset,
	input wire logic start,
	output logic done,
	output logic unstable,
	output logic [lpc_pkg::ADDR_W-1:0] mem_raddr,
	input wire logic [31:0] mem_rdata,
	output logic [lpc_pkg::ADDR_W-1:0] mem_waddr,
	output logic [31:0] mem_wdata,
	output logic mem_we
);

	logic div_start;
	lpc_pkg::dpf_t div_num;
	lpc_pkg::dpf_t div_den;
	logic div_done;
	lpc_pkg::dpf_t div_quot;

	logic norm_start;
	logic [31:0] norm_in;
	logic norm_done;
	lpc_pkg::dpf_t norm_mant;
	logic [4:0] norm_exp;

	logic cs_we;
	logic cs_bank;
	logic [3:0] cs_idx;
	lpc_pkg::dpf_t cs_wdata;
	logic cs_swap;
	logic [3:0] cs_idx_a;
	logic [3:0] cs_idx_b;
	lpc_pkg::dpf_t cs_rdata_a;
	lpc_pkg::dpf_t cs_rdata_b;

	lev_ctrl u_lev_ctrl (.*);

	div_32_unit u_div_32_unit (.*);

	alpha_norm u_alpha_norm (.*);

	coef_store u_coef_store (.*);

endmodule

`default_nettype wire

/* src/lpc_pkg.sv */
`default_nettype none

package lpc_pkg;

	localparam int ORDER = 10;
	localparam int ADDR_W = 12;

	// Scratch memory regions, low four bits are the index
	// R words hold r[i] as hi/lo halves, A and RC words are sign-extended 16-bit
	localparam logic [ADDR_W-1:0] R_BASE = 12'h100;
	localparam logic [ADDR_W-1:0] A_BASE = 12'h200;
	localparam logic [ADDR_W-1:0] RC_BASE = 12'h300;

	localparam logic [31:0] ONE_Q12 = 32'd4096;
	localparam int RC_LIMIT = 32750;
	localparam logic signed [31:0] MAX_32 = 32'sh7fff_ffff;
	localparam logic signed [31:0] MIN_32 = 32'sh8000_0000;
	localparam int DIV_STEPS = 15;

	// Controller states
	localparam int STATE_W = 4;
	localparam logic [STATE_W-1:0] S_IDLE = 4'd0;
	localparam logic [STATE_W-1:0] S_LOAD = 4'd1;
	localparam logic [STATE_W-1:0] S_SUM = 4'd2;
	localparam logic [STATE_W-1:0] S_DIV = 4'd3;
	localparam logic [STATE_W-1:0] S_RC = 4'd4;
	localparam logic [STATE_W-1:0] S_UPD = 4'd5;
	localparam logic [STATE_W-1:0] S_ALP = 4'd6;
	localparam logic [STATE_W-1:0] S_NORM = 4'd7;
	localparam logic [STATE_W-1:0] S_OUT = 4'd8;

	// Divider phases
	localparam logic [1:0] D_IDLE = 2'd0;
	localparam logic [1:0] D_STEP = 2'd1;
	localparam logic [1:0] D_INV = 2'd2;
	localparam logic [1:0] D_MUL = 2'd3;

	// Double-precision word, hi in [31:16] and lo = low 15 bits in [14:0]
	typedef union packed {
		logic signed [31:0] w;
		struct packed {
			logic signed [15:0] hi;
			logic pad;
			logic [14:0] lo;
		} hl;
	} dpf_t;

	////////////////////////////////////////
	// Basic operators

	function automatic logic signed [31:0] sat32(logic signed [32:0] s);
		if (s[32] != s[31]) begin
			return s[32] ? MIN_32 : MAX_32;
		end
		return s[31:0];
	endfunction

	function automatic logic signed [31:0] l_add(logic signed [31:0] a, logic signed [31:0] b);
		return sat32({a[31], a} + {b[31], b});
	endfunction

	function automatic logic signed [31:0] l_sub(logic signed [31:0] a, logic signed [31:0] b);
		return sat32({a[31], a} - {b[31], b});
	endfunction

	function automatic logic signed [31:0] l_shl(logic signed [31:0] x, logic [8:0] n);
		logic signed [31:0] r;
		r = x;
		for (int s = 0; s < 32; s++) begin
			if (s < n) begin
				if (r[31] != r[30]) begin
					r = r[31] ? MIN_32 : MAX_32;
				end else begin
					r = r <<< 1;
				end
			end
		end
		return r;
	endfunction

	function automatic logic signed [31:0] l_shr(logic signed [31:0] x, logic [4:0] n);
		return x >>> n;
	endfunction

	function automatic logic signed [31:0] l_abs(logic signed [31:0] x);
		if (x == MIN_32) begin
			return MAX_32;
		end
		return x[31] ? -x : x;
	endfunction

	function automatic logic signed [31:0] l_negate(logic signed [31:0] x);
		return (x == MIN_32) ? MAX_32 : -x;
	endfunction

	function automatic logic signed [31:0] l_mult(logic signed [15:0] a, logic signed [15:0] b);
		logic signed [31:0] p;
		p = a * b;
		return (p == 32'sh4000_0000) ? MAX_32 : p <<< 1;
	endfunction

	function automatic logic signed [15:0] mult(logic signed [15:0] a, logic signed [15:0] b);
		logic signed [31:0] p;
		p = (a * b) >>> 15;
		return (p > 32'sd32767) ? 16'sh7fff : p[15:0];
	endfunction

	function automatic dpf_t l_extract(logic signed [31:0] x);
		dpf_t d;
		d.hl.hi = x[31:16];
		d.hl.pad = 1'b0;
		d.hl.lo = x[15:1];
		return d;
	endfunction

	function automatic logic signed [31:0] l_comp(dpf_t d);
		return {d.hl.hi, d.hl.lo, 1'b0};
	endfunction

	function automatic logic signed [31:0] mpy_32(dpf_t a, dpf_t b);
		logic signed [31:0] l;
		l = l_mult(a.hl.hi, b.hl.hi);
		l = l_add(l, l_mult(mult(a.hl.hi, $signed({1'b0, b.hl.lo})), 16'sd1));
		l = l_add(l, l_mult(mult($signed({1'b0, a.hl.lo}), b.hl.hi), 16'sd1));
		return l;
	endfunction

	function automatic logic signed [31:0] mpy_32_16(dpf_t a, logic signed [15:0] n);
		logic signed [31:0] l;
		l = l_mult(a.hl.hi, n);
		l = l_add(l, l_mult(mult($signed({1'b0, a.hl.lo}), n), 16'sd1));
		return l;
	endfunction

	// Q27 double precision to rounded Q12
	function automatic logic signed [15:0] round_q12(dpf_t d);
		logic signed [31:0] t;
		t = l_add(l_shl(l_comp(d), 9'd1), 32'sh0000_8000);
		return t[31:16];
	endfunction

endpackage

`default_nettype wire

/* tb/lev_ref_model.svh */
`ifndef LEV_REF_MODEL_SVH
`define LEV_REF_MODEL_SVH

// Frame under test and the expected results
lpc_pkg::dpf_t r_vec [0:lpc_pkg::ORDER];
logic [31:0] exp_a [0:lpc_pkg::ORDER];
logic [31:0] exp_rc [0:lpc_pkg::ORDER-1];
logic exp_unstable;
int exp_nrc;

// Approximate inverse of den hi, one Newton step, then times num
function automatic logic signed [31:0] div_model(logic signed [31:0] num, lpc_pkg::dpf_t den);
	logic [15:0] rem;
	logic [15:0] approx;
	logic [16:0] rs;
	logic [16:0] diff;
	logic signed [31:0] err;
	lpc_pkg::dpf_t inv;
	rem = 16'h3fff;
	approx = 16'd0;
	for (int s = 0; s < lpc_pkg::DIV_STEPS; s++) begin
		rs = {rem, 1'b0};
		diff = rs - {1'b0, den.hl.hi};
		if (rs >= {1'b0, den.hl.hi}) begin
			rem = diff[15:0];
			approx = {approx[14:0], 1'b1};
		end else begin
			rem = rs[15:0];
			approx = {approx[14:0], 1'b0};
		end
	end
	err = lpc_pkg::l_sub(lpc_pkg::MAX_32, lpc_pkg::mpy_32_16(den, approx));
	inv = lpc_pkg::l_extract(lpc_pkg::mpy_32_16(lpc_pkg::l_extract(err), approx));
	return lpc_pkg::l_shl(lpc_pkg::mpy_32(lpc_pkg::l_extract(num), inv), 9'd2);
endfunction

task automatic run_model;
	lpc_pkg::dpf_t cur [1:lpc_pkg::ORDER];
	lpc_pkg::dpf_t nxt [1:lpc_pkg::ORDER];
	lpc_pkg::dpf_t alp;
	lpc_pkg::dpf_t k;
	logic [8:0] alp_exp;
	logic signed [31:0] acc;
	logic signed [31:0] t_sum;
	logic signed [31:0] q;
	logic signed [31:0] one_m_k2;
	logic [31:0] v;
	logic [4:0] sh;
	logic signed [15:0] a16;
	logic pos;
	int i;
	exp_unstable = 1'b0;
	exp_nrc = 0;
	for (int n = 1; n <= lpc_pkg::ORDER; n++) begin
		cur[n] = '0;
		nxt[n] = '0;
	end
	alp = r_vec[0];
	alp_exp = 9'd0;
	i = 1;
	while (i <= lpc_pkg::ORDER && !exp_unstable) begin
		acc = 32'sd0;
		for (int j = 1; j < i; j++) begin
			acc = lpc_pkg::l_add(acc, lpc_pkg::mpy_32(r_vec[j], cur[i-j]));
		end
		t_sum = lpc_pkg::l_add(lpc_pkg::l_shl(acc, 9'd4), lpc_pkg::l_comp(r_vec[i]));
		pos = (t_sum > 0);
		q = div_model(lpc_pkg::l_abs(t_sum), alp);
		if (pos) begin
			q = lpc_pkg::l_negate(q);
		end
		k = lpc_pkg::l_extract(lpc_pkg::l_shl(q, alp_exp));
		exp_rc[i-1] = {{16{k.hl.hi[15]}}, k.hl.hi};
		exp_nrc = i;
		if (i != 1 && (k.hl.hi > lpc_pkg::RC_LIMIT || k.hl.hi < -lpc_pkg::RC_LIMIT)) begin
			exp_unstable = 1'b1;
		end else begin
			// New coefficients a[j] + k*a[i-j], and a[i] = k >> 4
			if (i == 1) begin
				cur[1] = lpc_pkg::l_extract(lpc_pkg::l_shr(lpc_pkg::l_comp(k), 5'd4));
			end else begin
				for (int j = 1; j < i; j++) begin
					nxt[j] = lpc_pkg::l_extract(lpc_pkg::l_add(
						lpc_pkg::mpy_32(k, cur[i-j]), lpc_pkg::l_comp(cur[j])));
				end
				nxt[i] = lpc_pkg::l_extract(lpc_pkg::l_shr(lpc_pkg::l_comp(k), 5'd4));
				for (int j = 1; j <= i; j++) begin
					cur[j] = nxt[j];
				end
			end
			// alpha * (1 - k^2), then normalize as norm_L
			one_m_k2 = lpc_pkg::l_sub(lpc_pkg::MAX_32,
				lpc_pkg::l_abs(lpc_pkg::mpy_32(k, k)));
			v = lpc_pkg::mpy_32(alp, lpc_pkg::l_extract(one_m_k2));
			sh = 5'd0;
			while (!(v == 32'd0 || v[30] != v[31])) begin
				v = {v[30:0], 1'b0};
				sh = sh + 5'd1;
			end
			alp = lpc_pkg::l_extract(v);
			alp_exp = alp_exp + sh;
			i = i + 1;
		end
	end
	exp_a[0] = lpc_pkg::ONE_Q12;
	for (int j = 1; j <= lpc_pkg::ORDER; j++) begin
		a16 = lpc_pkg::round_q12(cur[j]);
		exp_a[j] = {{16{a16[15]}}, a16};
	end
endtask

`endif

/* tb/tb_lev_durbin.sv */
`default_nettype none

module tb_lev_durbin;

	logic clock = 1'b0;
	logic reset;
	logic start;
	logic done;
	logic unstable;
	logic [lpc_pkg::ADDR_W-1:0] mem_raddr;
	logic [31:0] mem_rdata = 32'd0;
	logic [lpc_pkg::ADDR_W-1:0] mem_waddr;
	logic [31:0] mem_wdata;
	logic mem_we;

	logic [31:0] mem [0:4095];
	integer seed;
	int errors;
	int checks;

	`include "lev_ref_model.svh"

	lev_durbin_top u_lev_durbin_top (
		.clock(clock),
		.reset(reset),
		.start(start),
		.done(done),
		.unstable(unstable),
		.mem_raddr(mem_raddr),
		.mem_rdata(mem_rdata),
		.mem_waddr(mem_waddr),
		.mem_wdata(mem_wdata),
		.mem_we(mem_we)
	);

	always #20 clock = ~clock;

	// Scratch memory with one cycle of read latency
	always @(posedge clock) begin
		mem_rdata <= mem[mem_raddr];
		if (mem_we) begin
			mem[mem_waddr] <= mem_wdata;
		end
	end

	function automatic logic [31:0] fill_word(int addr);
		return {4'ha, addr[11:0], 4'h5, addr[11:0]};
	endfunction

	////////////////////////////////////////
	// Helpers

	task automatic preset_memory;
		for (int n = 0; n < 4096; n++) begin
			mem[n] = fill_word(n);
		end
	endtask

	task automatic load_frame;
		for (int n = 0; n <= lpc_pkg::ORDER; n++) begin
			mem[lpc_pkg::R_BASE + n] = r_vec[n].w;
		end
	endtask

	task automatic pulse_start;
		@(negedge clock);
		start = 1'b1;
		@(negedge clock);
		start = 1'b0;
	endtask

	task automatic wait_done(output logic flag_unstable);
		int n;
		logic seen;
		seen = 1'b0;
		flag_unstable = 1'b0;
		n = 0;
		while (!seen && n < 4000) begin
			@(negedge clock);
			n++;
			if (done) begin
				seen = 1'b1;
				flag_unstable = unstable;
			end
		end
		if (!seen) begin
			$display("no done pulse arrived within 4000 cycles");
			errors++;
		end
	endtask

	task automatic check_word(int addr, logic [31:0] expected, string what, int idx);
		checks++;
		if (mem[addr] !== expected) begin
			$display("error %0t: %s[%0d] is %h, expected %h", $time, what, idx,
				mem[addr], expected);
			errors++;
		end
	endtask

	task automatic check_results(logic got_unstable);
		checks++;
		if (got_unstable !== exp_unstable) begin
			$display("error %0t: unstable is %b, expected %b", $time, got_unstable,
				exp_unstable);
			errors++;
		end
		for (int j = 0; j < lpc_pkg::ORDER; j++) begin
			if (j < exp_nrc) begin
				check_word(lpc_pkg::RC_BASE + j, exp_rc[j], "rc", j);
			end else begin
				check_word(lpc_pkg::RC_BASE + j, fill_word(lpc_pkg::RC_BASE + j), "rc", j);
			end
		end
		// Unstable frames leave the A region untouched
		for (int j = 0; j <= lpc_pkg::ORDER; j++) begin
			if (exp_unstable) begin
				check_word(lpc_pkg::A_BASE + j, fill_word(lpc_pkg::A_BASE + j), "a", j);
			end else begin
				check_word(lpc_pkg::A_BASE + j, exp_a[j], "a", j);
			end
		end
	endtask

	task automatic run_frame;
		logic got;
		preset_memory();
		load_frame();
		run_model();
		pulse_start();
		wait_done(got);
		check_results(got);
	endtask

	// Damped cosine autocorrelation with a small noise floor
	task automatic build_fixed_frame;
		logic signed [15:0] hi [0:10];
		hi = '{16'sd16548, 16'sd12942, 16'sd7170, 16'sd844, -16'sd4473, -16'sd7751,
			-16'sd8620, -16'sd7338, -16'sd4611, -16'sd1339, 16'sd1620};
		for (int n = 0; n <= lpc_pkg::ORDER; n++) begin
			r_vec[n] = lpc_pkg::l_extract({hi[n], 16'h0000});
		end
	endtask

	task automatic build_random_frame;
		longint x;
		longint rho;
		longint noise;
		logic signed [31:0] t;
		rho = 16384 + ($unsigned($random(seed)) % 14000);
		x = 64'sd1073741824 + ($unsigned($random(seed)) % 65536);
		t = x[31:0];
		r_vec[0] = lpc_pkg::l_extract(t);
		for (int n = 1; n <= lpc_pkg::ORDER; n++) begin
			x = (x * rho) >>> 15;
			noise = $random(seed) % 2048;
			t = x[31:0] + noise[31:0];
			r_vec[n] = lpc_pkg::l_extract(t);
		end
	endtask

	////////////////////////////////////////
	// Tests

	task automatic test_after_reset;
		for (int n = 0; n < 20; n++) begin
			@(negedge clock);
			checks++;
			if (done !== 1'b0 || unstable !== 1'b0 || mem_we !== 1'b0) begin
				$display("error %0t: idle outputs done=%b unstable=%b mem_we=%b", $time,
					done, unstable, mem_we);
				errors++;
			end
		end
	endtask

	task automatic test_fixed_vector;
		build_fixed_frame();
		run_frame();
		checks++;
		if (exp_unstable) begin
			$display("error %0t: fixed vector was judged unstable", $time);
			errors++;
		end
	endtask

	task automatic test_random_frames;
		int good;
		int tries;
		good = 0;
		tries = 0;
		while (good < 8 && tries < 40) begin
			tries++;
			build_random_frame();
			run_model();
			if (!exp_unstable) begin
				run_frame();
				good++;
			end
		end
		if (good < 8) begin
			$display("only %0d stable random frames could be built", good);
			errors++;
		end
	endtask

	task automatic test_unstable_frame;
		build_fixed_frame();
		// r1 close to r0 leaves alpha tiny, so order 2 blows up
		r_vec[1] = lpc_pkg::l_extract({16'sd16540, 16'h0000});
		run_model();
		if (!exp_unstable) begin
			$display("the unstable frame was not judged unstable by the model");
			errors++;
		end
		run_frame();
	endtask

	task automatic test_start_while_busy;
		logic got;
		build_fixed_frame();
		preset_memory();
		load_frame();
		run_model();
		pulse_start();
		repeat (30) @(negedge clock);
		// The frame is loaded by now, a restart would read this one
		for (int n = 0; n <= lpc_pkg::ORDER; n++) begin
			mem[lpc_pkg::R_BASE + n] = 32'd0;
		end
		start = 1'b1;
		@(negedge clock);
		start = 1'b0;
		wait_done(got);
		check_results(got);
		// Second run straight after done
		build_random_frame();
		preset_memory();
		load_frame();
		run_model();
		start = 1'b1;
		@(negedge clock);
		start = 1'b0;
		wait_done(got);
		check_results(got);
	endtask

	initial begin
		#(6 * 4000 * 40);
		$display("timeout: the tests did not finish in time");
		$display("sim failed");
		$finish;
	end

	initial begin
		seed = 32'he59b13ef;
		errors = 0;
		checks = 0;
		start = 1'b0;
		reset = 1'b1;
		preset_memory();
		repeat (5) @(negedge clock);
		reset = 1'b0;
		test_after_reset();
		test_fixed_vector();
		test_random_frames();
		test_unstable_frame();
		test_start_while_busy();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
